// File: rtl/io_core_pkg.sv
package io_core_pkg;

  ////////////////////////////////////////////////////////////
  // I/O offset views
  ////////////////////////////////////////////////////////////

  // The low seven address bits, seen as doubleword or word registers
  typedef union packed {
    struct packed {
      logic [3:0] idx;
      logic       lane;
      logic [1:0] byte_off;
    } dw;
    struct packed {
      logic [4:0] idx;
      logic [1:0] byte_off;
    } w;
  } io_offset_u;

  ////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////

  // Doubleword registers
  localparam logic [3:0] SEND_DESC_IDX = 4'b0000;
  localparam logic [3:0] WR_DRAM_IDX   = 4'b0001;
  localparam logic [3:0] RD_DESC_IDX   = 4'b1000;

  // Word registers
  localparam logic [4:0] TIMER_STEP_IDX = 5'b00101;
  localparam logic [4:0] DRAM_FLAG_IDX  = 5'b00110;
  localparam logic [4:0] RD_FLAGS_IDX   = 5'b10010;
  localparam logic [4:0] RD_STAT_IDX    = 5'b10011;
  localparam logic [4:0] RD_ID_IDX      = 5'b10100;
  localparam logic [4:0] RD_TIMER_L_IDX = 5'b10101;
  localparam logic [4:0] RD_TIMER_H_IDX = 5'b10110;
  localparam logic [4:0] RD_INT_F_IDX   = 5'b10111;

  // Strobe locations, matched on the full offset
  localparam logic [6:0] SEND_DESC_STRB = 7'b0111000;
  localparam logic [6:0] RD_DESC_STRB   = 7'b0111001;
  localparam logic [6:0] DRAM_FLAG_RST  = 7'b0111010;
  localparam logic [6:0] MASK_WR        = 7'b0111100;
  localparam logic [6:0] INTERRUPT_ACK  = 7'b0111101;

  ////////////////////////////////////////////////////////////
  // Reset values and bit positions
  ////////////////////////////////////////////////////////////

  // Timer, DRAM receive and incoming descriptor interrupts blocked
  localparam logic [7:0]  MASK_RESET       = 8'h1F;
  localparam logic [31:0] TIMER_STEP_RESET = 32'd1;

  localparam int ACK_EXT_BIT   = 12;
  localparam int ACK_TIMER_BIT = 13;

  localparam int MASK_EXT_BIT   = 4;
  localparam int MASK_TIMER_BIT = 5;
  localparam int MASK_DRAM_BIT  = 6;
  localparam int MASK_DESC_BIT  = 7;

endpackage

// File: rtl/io_decode.sv
`timescale 1ns/1ns

module io_decode #(
  parameter int addr_width = 16
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  dbus_valid,
  input  logic                  dbus_wr,
  input  logic [addr_width-1:0] dbus_addr,
  input  logic [31:0]           dbus_wdata,
  input  logic [1:0]            dbus_size,
  output logic                  ext_dmem_en,
  output logic [3:0]            ext_dmem_wen,
  output logic                  desc_wen,
  output logic                  dram_addr_wen,
  output logic                  step_wen,
  output logic                  flags_wen,
  output logic                  send_strb,
  output logic                  take_strb,
  output logic                  flag_clr,
  output logic                  mask_wen,
  output logic                  ack,
  output logic [7:0]            byte_mask,
  output logic [63:0]           wdata_rep,
  output logic [4:0]            rd_sel,
  output logic                  rd_lane,
  output logic                  io_rd
);

  io_core_pkg::io_offset_u off;
  logic       io_not_mem;
  logic       io_write;
  logic [3:0] word_mask;
  logic       strb_set;

  assign off        = dbus_addr[6:0];
  assign io_not_mem = dbus_addr[addr_width-1];
  assign io_write   = dbus_valid && dbus_wr && io_not_mem;

  // Byte lanes of the word from the access size
  always_comb begin
    word_mask = 4'b0000;
    if (dbus_valid && dbus_wr) begin
      case (dbus_size)
        2'd0:    word_mask = 4'b0001 << dbus_addr[1:0];
        2'd1:    word_mask = 4'b0011 << dbus_addr[1:0];
        default: word_mask = 4'b1111;
      endcase
    end
  end

  assign ext_dmem_en  = dbus_valid && !io_not_mem;
  assign ext_dmem_wen = ext_dmem_en ? word_mask : 4'b0000;

  // Registers are laid out as doublewords, so move the mask to its lane
  assign byte_mask = {4'b0000, word_mask} << {off.dw.lane, 2'b00};
  assign wdata_rep = {dbus_wdata, dbus_wdata};

  ////////////////////////////////////////////////////////////
  // Register writes and strobes
  ////////////////////////////////////////////////////////////

  // Narrow stores replicate the byte, so bit 0 is valid for any lane
  assign strb_set = dbus_wdata[0];

  assign desc_wen      = io_write && (off.dw.idx == io_core_pkg::SEND_DESC_IDX);
  assign dram_addr_wen = io_write && (off.dw.idx == io_core_pkg::WR_DRAM_IDX);
  assign step_wen      = io_write && (off.w.idx == io_core_pkg::TIMER_STEP_IDX);
  assign flags_wen     = io_write && (off.w.idx == io_core_pkg::DRAM_FLAG_IDX);

  assign send_strb = io_write && (off == io_core_pkg::SEND_DESC_STRB) && strb_set;
  assign take_strb = io_write && (off == io_core_pkg::RD_DESC_STRB) && strb_set;
  assign flag_clr  = io_write && (off == io_core_pkg::DRAM_FLAG_RST);
  assign mask_wen  = io_write && (off == io_core_pkg::MASK_WR);
  assign ack       = io_write && (off == io_core_pkg::INTERRUPT_ACK);

  // Read select goes to the read mux in the command cycle
  assign rd_sel  = off.w.idx;
  assign rd_lane = off.dw.lane;

  always_ff @(posedge clk) begin
    if (rst) begin
      io_rd <= 1'b0;
    end else begin
      io_rd <= dbus_valid && !dbus_wr && io_not_mem;
    end
  end

  a_one_io_target: assert property (@(posedge clk) disable iff (rst)
    $onehot0({desc_wen, dram_addr_wen, step_wen, flags_wen,
              send_strb, take_strb, flag_clr, mask_wen, ack}));

endmodule

// File: rtl/io_control_regs.sv
`timescale 1ns/1ns

module io_control_regs (
  input  logic        clk,
  input  logic        rst,
  input  logic        desc_wen,
  input  logic        dram_addr_wen,
  input  logic        send_strb,
  input  logic        take_strb,
  input  logic        mask_wen,
  input  logic        ack,
  input  logic [7:0]  byte_mask,
  input  logic [63:0] wdata_rep,
  input  logic        data_desc_ready,
  input  logic        in_desc_valid,
  input  logic        interrupt_in,
  input  logic        dram_recv_any,
  input  logic        timer_irq_raw,
  output logic [63:0] data_desc,
  output logic        data_desc_valid,
  output logic [63:0] dram_wr_addr,
  output logic        in_desc_taken,
  output logic        interrupt_in_ack,
  output logic [7:0]  mask,
  output logic        timer_irq,
  output logic        ext_irq
);

  ////////////////////////////////////////////////////////////
  // Byte writable descriptor and DRAM address
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    for (int i = 0; i < 8; i++) begin
      if (desc_wen && byte_mask[i]) begin
        data_desc[i*8 +: 8] <= wdata_rep[i*8 +: 8];
      end
      if (dram_addr_wen && byte_mask[i]) begin
        dram_wr_addr[i*8 +: 8] <= wdata_rep[i*8 +: 8];
      end
    end
  end

  // Mask sits in the first byte of the upper lane
  always_ff @(posedge clk) begin
    if (rst) begin
      mask <= io_core_pkg::MASK_RESET;
    end else if (mask_wen && byte_mask[4]) begin
      mask <= wdata_rep[39:32];
    end
  end

  ////////////////////////////////////////////////////////////
  // Outgoing descriptor handshake
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      data_desc_valid <= 1'b0;
    end else if (data_desc_valid && data_desc_ready) begin
      data_desc_valid <= 1'b0;
    end else if (send_strb) begin
      data_desc_valid <= 1'b1;
    end
  end

  assign in_desc_taken = take_strb;

  // One-cycle ack back to the external interrupt source
  always_ff @(posedge clk) begin
    if (rst) begin
      interrupt_in_ack <= 1'b0;
    end else begin
      interrupt_in_ack <= ack && wdata_rep[io_core_pkg::ACK_EXT_BIT];
    end
  end

  ////////////////////////////////////////////////////////////
  // Interrupt gating
  ////////////////////////////////////////////////////////////

  assign timer_irq = timer_irq_raw && mask[io_core_pkg::MASK_TIMER_BIT];

  assign ext_irq = (interrupt_in  && mask[io_core_pkg::MASK_EXT_BIT])  ||
                   (dram_recv_any && mask[io_core_pkg::MASK_DRAM_BIT]) ||
                   (in_desc_valid && mask[io_core_pkg::MASK_DESC_BIT]);

  // Fabric must see the descriptor until it takes it
  a_desc_held: assert property (@(posedge clk) disable iff (rst)
    data_desc_valid && !data_desc_ready |=> data_desc_valid && $stable(data_desc));

endmodule

// File: rtl/core_timer.sv
`timescale 1ns/1ns

module core_timer (
  input  logic        clk,
  input  logic        rst,
  input  logic        step_wen,
  input  logic        ack,
  input  logic [7:0]  byte_mask,
  input  logic [63:0] wdata_rep,
  output logic [63:0] timer_value,
  output logic        timer_irq_raw
);

  logic [31:0] step;
  logic [31:0] interval;

  // Free running, counts edges since reset
  always_ff @(posedge clk) begin
    if (rst) begin
      timer_value <= 64'd0;
    end else begin
      timer_value <= timer_value + 64'd1;
    end
  end

  // Step register lives in the upper lane
  always_ff @(posedge clk) begin
    if (rst) begin
      step <= io_core_pkg::TIMER_STEP_RESET;
    end else if (step_wen) begin
      for (int i = 0; i < 4; i++) begin
        if (byte_mask[i+4]) begin
          step[i*8 +: 8] <= wdata_rep[(i+4)*8 +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Periodic interrupt
  ////////////////////////////////////////////////////////////

  // A new step restarts the interval, so the first tick is step+1 away
  always_ff @(posedge clk) begin
    if (rst || step_wen) begin
      interval      <= 32'd0;
      timer_irq_raw <= 1'b0;
    end else if (interval == step) begin
      interval      <= 32'd0;
      timer_irq_raw <= 1'b1;
    end else begin
      interval <= interval + 32'd1;
      if (ack && wdata_rep[io_core_pkg::ACK_TIMER_BIT]) begin
        timer_irq_raw <= 1'b0;
      end
    end
  end

endmodule

// File: rtl/dram_recv_flags.sv
`timescale 1ns/1ns

module dram_recv_flags (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  recv_dram_tag,
  input  logic        recv_dram_tag_valid,
  input  logic        flags_wen,
  input  logic        flag_clr,
  input  logic [7:0]  byte_mask,
  input  logic [63:0] wdata_rep,
  output logic [31:0] dram_flags,
  output logic        dram_recv_any
);

  logic [4:0] tag_r;
  logic       tag_valid_r;

  // Fabric input is registered for timing
  always_ff @(posedge clk) begin
    tag_r <= recv_dram_tag;
    if (rst) begin
      tag_valid_r <= 1'b0;
    end else begin
      tag_valid_r <= recv_dram_tag_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dram_flags <= 32'd0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (flags_wen && byte_mask[i]) begin
          dram_flags[i*8 +: 8] <= wdata_rep[i*8 +: 8];
        end
      end
      if (flag_clr) begin
        dram_flags[wdata_rep[20:16]] <= 1'b0;
      end
      // A tag arriving with a clear of the same bit still sets it
      if (tag_valid_r) begin
        dram_flags[tag_r] <= 1'b1;
      end
      // Tag 0 means no DRAM transfer
      dram_flags[0] <= 1'b0;
    end
  end

  assign dram_recv_any = |dram_flags;

  // Tag 0 leaves bit 0 clear and any other tag sets its flag even against a clear
  a_tag_sets_flag: assert property (@(posedge clk) disable iff (rst)
    tag_valid_r |=> dram_flags[$past(tag_r)] == ($past(tag_r) != 5'd0));

endmodule

// File: rtl/io_read_mux.sv
`timescale 1ns/1ns

module io_read_mux #(
  parameter int core_id_width = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     io_rd,
  input  logic [4:0]               rd_sel,
  input  logic                     rd_lane,
  input  logic [63:0]              in_desc,
  input  logic                     in_desc_valid,
  input  logic [31:0]              dram_flags,
  input  logic [63:0]              timer_value,
  input  logic [7:0]               mask,
  input  logic                     dram_recv_any,
  input  logic                     timer_irq_raw,
  input  logic                     interrupt_in,
  input  logic [core_id_width-1:0] core_id,
  input  logic                     data_desc_ready,
  input  logic [31:0]              ext_dmem_rd_data,
  input  logic                     ext_dmem_rd_valid,
  output logic                     dbus_rsp_valid,
  output logic [31:0]              dbus_rsp_data
);

  logic [31:0] rd_word;
  logic [31:0] io_read_data;

  ////////////////////////////////////////////////////////////
  // Read word select
  ////////////////////////////////////////////////////////////

  always_comb begin
    rd_word = 32'd0;
    if (rd_sel[4:1] == io_core_pkg::RD_DESC_IDX) begin
      rd_word = rd_lane ? in_desc[63:32] : in_desc[31:0];
    end else begin
      case (rd_sel)
        io_core_pkg::RD_FLAGS_IDX:   rd_word = dram_flags;
        // One flag per byte, upper two bytes reserved
        io_core_pkg::RD_STAT_IDX:    rd_word = {8'd0, 8'd0,
                                                7'd0, data_desc_ready,
                                                7'd0, in_desc_valid};
        io_core_pkg::RD_ID_IDX:      rd_word = {{(32-core_id_width){1'b0}}, core_id};
        io_core_pkg::RD_TIMER_L_IDX: rd_word = timer_value[31:0];
        io_core_pkg::RD_TIMER_H_IDX: rd_word = timer_value[63:32];
        io_core_pkg::RD_INT_F_IDX:   rd_word = {16'd0, mask,
                                                in_desc_valid, dram_recv_any,
                                                timer_irq_raw, interrupt_in, 4'd0};
        default:                     rd_word = 32'd0;
      endcase
    end
  end

  // Value as of the command cycle, returned on the next one
  always_ff @(posedge clk) begin
    if (rst) begin
      io_read_data <= 32'd0;
    end else begin
      io_read_data <= rd_word;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response merge
  ////////////////////////////////////////////////////////////

  assign dbus_rsp_valid = io_rd || ext_dmem_rd_valid;
  assign dbus_rsp_data  = io_rd ? io_read_data : ext_dmem_rd_data;

endmodule

// File: rtl/io_core_top.sv
`timescale 1ns/1ns

module io_core_top #(
  parameter int addr_width    = 16,
  parameter int core_id_width = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  // Core data bus
  input  logic                     dbus_valid,
  input  logic                     dbus_wr,
  input  logic [addr_width-1:0]    dbus_addr,
  input  logic [31:0]              dbus_wdata,
  input  logic [1:0]               dbus_size,
  output logic                     dbus_rsp_valid,
  output logic [31:0]              dbus_rsp_data,
  // Data memory
  output logic                     ext_dmem_en,
  output logic [3:0]               ext_dmem_wen,
  output logic [addr_width-1:0]    ext_dmem_addr,
  output logic [31:0]              ext_dmem_wr_data,
  input  logic [31:0]              ext_dmem_rd_data,
  input  logic                     ext_dmem_rd_valid,
  // Fabric
  input  logic [63:0]              in_desc,
  input  logic                     in_desc_valid,
  output logic                     in_desc_taken,
  output logic [63:0]              data_desc,
  output logic                     data_desc_valid,
  input  logic                     data_desc_ready,
  output logic [63:0]              dram_wr_addr,
  input  logic [4:0]               recv_dram_tag,
  input  logic                     recv_dram_tag_valid,
  input  logic                     interrupt_in,
  output logic                     interrupt_in_ack,
  input  logic [core_id_width-1:0] core_id,
  // Interrupts to the core
  output logic                     timer_irq,
  output logic                     ext_irq
);

  logic        desc_wen;
  logic        dram_addr_wen;
  logic        step_wen;
  logic        flags_wen;
  logic        send_strb;
  logic        take_strb;
  logic        flag_clr;
  logic        mask_wen;
  logic        ack;
  logic [7:0]  byte_mask;
  logic [63:0] wdata_rep;
  logic [4:0]  rd_sel;
  logic        rd_lane;
  logic        io_rd;
  logic [7:0]  mask;
  logic [63:0] timer_value;
  logic        timer_irq_raw;
  logic [31:0] dram_flags;
  logic        dram_recv_any;

  assign ext_dmem_addr    = dbus_addr;
  assign ext_dmem_wr_data = dbus_wdata;

  io_decode #(
    .addr_width (addr_width)
  ) u_io_decode (
    .clk           (clk),
    .rst           (rst),
    .dbus_valid    (dbus_valid),
    .dbus_wr       (dbus_wr),
    .dbus_addr     (dbus_addr),
    .dbus_wdata    (dbus_wdata),
    .dbus_size     (dbus_size),
    .ext_dmem_en   (ext_dmem_en),
    .ext_dmem_wen  (ext_dmem_wen),
    .desc_wen      (desc_wen),
    .dram_addr_wen (dram_addr_wen),
    .step_wen      (step_wen),
    .flags_wen     (flags_wen),
    .send_strb     (send_strb),
    .take_strb     (take_strb),
    .flag_clr      (flag_clr),
    .mask_wen      (mask_wen),
    .ack           (ack),
    .byte_mask     (byte_mask),
    .wdata_rep     (wdata_rep),
    .rd_sel        (rd_sel),
    .rd_lane       (rd_lane),
    .io_rd         (io_rd)
  );

  io_control_regs u_io_control_regs (
    .clk              (clk),
    .rst              (rst),
    .desc_wen         (desc_wen),
    .dram_addr_wen    (dram_addr_wen),
    .send_strb        (send_strb),
    .take_strb        (take_strb),
    .mask_wen         (mask_wen),
    .ack              (ack),
    .byte_mask        (byte_mask),
    .wdata_rep        (wdata_rep),
    .data_desc_ready  (data_desc_ready),
    .in_desc_valid    (in_desc_valid),
    .interrupt_in     (interrupt_in),
    .dram_recv_any    (dram_recv_any),
    .timer_irq_raw    (timer_irq_raw),
    .data_desc        (data_desc),
    .data_desc_valid  (data_desc_valid),
    .dram_wr_addr     (dram_wr_addr),
    .in_desc_taken    (in_desc_taken),
    .interrupt_in_ack (interrupt_in_ack),
    .mask             (mask),
    .timer_irq        (timer_irq),
    .ext_irq          (ext_irq)
  );

  core_timer u_core_timer (
    .clk           (clk),
    .rst           (rst),
    .step_wen      (step_wen),
    .ack           (ack),
    .byte_mask     (byte_mask),
    .wdata_rep     (wdata_rep),
    .timer_value   (timer_value),
    .timer_irq_raw (timer_irq_raw)
  );

  dram_recv_flags u_dram_recv_flags (
    .clk                 (clk),
    .rst                 (rst),
    .recv_dram_tag       (recv_dram_tag),
    .recv_dram_tag_valid (recv_dram_tag_valid),
    .flags_wen           (flags_wen),
    .flag_clr            (flag_clr),
    .byte_mask           (byte_mask),
    .wdata_rep           (wdata_rep),
    .dram_flags          (dram_flags),
    .dram_recv_any       (dram_recv_any)
  );

  io_read_mux #(
    .core_id_width (core_id_width)
  ) u_io_read_mux (
    .clk               (clk),
    .rst               (rst),
    .io_rd             (io_rd),
    .rd_sel            (rd_sel),
    .rd_lane           (rd_lane),
    .in_desc           (in_desc),
    .in_desc_valid     (in_desc_valid),
    .dram_flags        (dram_flags),
    .timer_value       (timer_value),
    .mask              (mask),
    .dram_recv_any     (dram_recv_any),
    .timer_irq_raw     (timer_irq_raw),
    .interrupt_in      (interrupt_in),
    .core_id           (core_id),
    .data_desc_ready   (data_desc_ready),
    .ext_dmem_rd_data  (ext_dmem_rd_data),
    .ext_dmem_rd_valid (ext_dmem_rd_valid),
    .dbus_rsp_valid    (dbus_rsp_valid),
    .dbus_rsp_data     (dbus_rsp_data)
  );

endmodule

// File: tb/tb_io_core.sv
`timescale 1ns/1ns

module tb_io_core;

  localparam int          ADDR_WIDTH     = 16;
  localparam int          CORE_ID_WIDTH  = 4;
  localparam int          MAX_LINES      = 128;
  localparam int          RSP_WAIT_LIMIT = 8;
  localparam int          IRQ_WAIT_LIMIT = 64;
  localparam logic [63:0] IN_DESC        = 64'h11223344_55667788;
  localparam logic [3:0]  CORE_ID        = 4'hA;

  logic                     clk;
  logic                     rst;
  logic                     dbus_valid;
  logic                     dbus_wr;
  logic [ADDR_WIDTH-1:0]    dbus_addr;
  logic [31:0]              dbus_wdata;
  logic [1:0]               dbus_size;
  logic                     dbus_rsp_valid;
  logic [31:0]              dbus_rsp_data;
  logic                     ext_dmem_en;
  logic [3:0]               ext_dmem_wen;
  logic [ADDR_WIDTH-1:0]    ext_dmem_addr;
  logic [31:0]              ext_dmem_wr_data;
  logic [31:0]              mem_rd_data;
  logic                     mem_rd_valid;
  logic [63:0]              in_desc;
  logic                     in_desc_valid;
  logic                     in_desc_taken;
  logic [63:0]              data_desc;
  logic                     data_desc_valid;
  logic                     data_desc_ready;
  logic [63:0]              dram_wr_addr;
  logic [4:0]               recv_dram_tag;
  logic                     recv_dram_tag_valid;
  logic                     interrupt_in;
  logic                     interrupt_in_ack;
  logic [CORE_ID_WIDTH-1:0] core_id;
  logic                     timer_irq;
  logic                     ext_irq;

  // Stimulus table, one entry per operation line
  logic [63:0] st_op   [0:MAX_LINES-1];
  logic [63:0] st_addr [0:MAX_LINES-1];
  logic [63:0] st_data [0:MAX_LINES-1];
  logic [63:0] st_size [0:MAX_LINES-1];
  logic [63:0] st_exp  [0:MAX_LINES-1];
  int          n_lines;

  logic [31:0] mem [0:255];
  int          errors;
  int          checks;
  int          cycle;
  int          rel_cycle;
  int          limit;
  bit          limit_set;
  bit          have_prev_timer;
  logic [31:0] prev_timer;
  int          prev_edges;

  io_core_top #(
    .addr_width    (ADDR_WIDTH),
    .core_id_width (CORE_ID_WIDTH)
  ) u_io_core_top (
    .clk                 (clk),
    .rst                 (rst),
    .dbus_valid          (dbus_valid),
    .dbus_wr             (dbus_wr),
    .dbus_addr           (dbus_addr),
    .dbus_wdata          (dbus_wdata),
    .dbus_size           (dbus_size),
    .dbus_rsp_valid      (dbus_rsp_valid),
    .dbus_rsp_data       (dbus_rsp_data),
    .ext_dmem_en         (ext_dmem_en),
    .ext_dmem_wen        (ext_dmem_wen),
    .ext_dmem_addr       (ext_dmem_addr),
    .ext_dmem_wr_data    (ext_dmem_wr_data),
    .ext_dmem_rd_data    (mem_rd_data),
    .ext_dmem_rd_valid   (mem_rd_valid),
    .in_desc             (in_desc),
    .in_desc_valid       (in_desc_valid),
    .in_desc_taken       (in_desc_taken),
    .data_desc           (data_desc),
    .data_desc_valid     (data_desc_valid),
    .data_desc_ready     (data_desc_ready),
    .dram_wr_addr        (dram_wr_addr),
    .recv_dram_tag       (recv_dram_tag),
    .recv_dram_tag_valid (recv_dram_tag_valid),
    .interrupt_in        (interrupt_in),
    .interrupt_in_ack    (interrupt_in_ack),
    .core_id             (core_id),
    .timer_irq           (timer_irq),
    .ext_irq             (ext_irq)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Data memory, answers one cycle after the command
  always @(posedge clk) begin : dmem_model
    logic [31:0] word;
    word = mem[ext_dmem_addr[9:2]];
    mem_rd_valid <= 1'b0;
    if (ext_dmem_en) begin
      for (int b = 0; b < 4; b++) begin
        if (ext_dmem_wen[b]) begin
          word[b*8 +: 8] = ext_dmem_wr_data[b*8 +: 8];
        end
      end
      mem[ext_dmem_addr[9:2]] <= word;
      if (ext_dmem_wen == 4'b0000) begin
        mem_rd_data  <= word;
        mem_rd_valid <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks and bus operations
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic bus_write(input logic [15:0] addr, input logic [31:0] data,
                           input logic [1:0] size, input logic [3:0] exp_wen);
    io_core_pkg::io_offset_u off;
    logic exp_take;
    logic exp_ack;
    off      = addr[6:0];
    exp_take = addr[15] && (off == io_core_pkg::RD_DESC_STRB) && data[0];
    exp_ack  = addr[15] && (off == io_core_pkg::INTERRUPT_ACK) && data[12];
    dbus_valid = 1'b1;
    dbus_wr    = 1'b1;
    dbus_addr  = addr;
    dbus_wdata = data;
    dbus_size  = size;
    #2;
    check_value("ext_dmem_en", ext_dmem_en, !addr[15]);
    check_value("ext_dmem_wen", ext_dmem_wen, exp_wen);
    check_value("in_desc_taken", in_desc_taken, exp_take);
    @(negedge clk);
    dbus_valid = 1'b0;
    dbus_wr    = 1'b0;
    check_value("interrupt_in_ack", interrupt_in_ack, exp_ack);
    // Ack pulse lasts a single cycle
    if (exp_ack) begin
      @(negedge clk);
      check_value("interrupt_in_ack", interrupt_in_ack, 1'b0);
    end
  endtask

  task automatic bus_read(input logic [15:0] addr, input logic [1:0] size,
                          output logic [31:0] rdata);
    int waited;
    dbus_valid = 1'b1;
    dbus_wr    = 1'b0;
    dbus_addr  = addr;
    dbus_wdata = 32'd0;
    dbus_size  = size;
    #2;
    check_value("ext_dmem_en", ext_dmem_en, !addr[15]);
    @(negedge clk);
    dbus_valid = 1'b0;
    waited     = 0;
    while (!dbus_rsp_valid && waited < RSP_WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    rdata = dbus_rsp_data;
    if (!dbus_rsp_valid) begin
      errors++;
      $display("No read response for address %h within %0d cycles", addr, RSP_WAIT_LIMIT);
    end else begin
      @(negedge clk);
      check_value("dbus_rsp_valid", dbus_rsp_valid, 1'b0);
    end
  endtask

  task automatic pulse_tag(input logic [4:0] tag);
    recv_dram_tag       = tag;
    recv_dram_tag_valid = 1'b1;
    @(negedge clk);
    recv_dram_tag_valid = 1'b0;
  endtask

  // Strobe, then hold ready low for a random stall
  task automatic send_descriptor(input logic [15:0] addr, input logic [31:0] data,
                                 input logic [63:0] exp_desc);
    int stall;
    bus_write(addr, data, 2'd2, 4'h0);
    check_value("data_desc_valid", data_desc_valid, 1'b1);
    check_value("data_desc", data_desc, exp_desc);
    stall = $urandom % 5;
    repeat (stall) begin
      @(negedge clk);
      check_value("data_desc_valid", data_desc_valid, 1'b1);
      check_value("data_desc", data_desc, exp_desc);
    end
    data_desc_ready = 1'b1;
    @(negedge clk);
    data_desc_ready = 1'b0;
    check_value("data_desc_valid", data_desc_valid, 1'b0);
  endtask

  // Two words and a byte into the top of the upper word
  task automatic dram_addr_writes();
    bus_write(16'h8008, 32'h76543210, 2'd2, 4'h0);
    bus_write(16'h800c, 32'h0000abcd, 2'd2, 4'h0);
    bus_write(16'h800f, 32'heeeeeeee, 2'd0, 4'h0);
    check_value("dram_wr_addr", dram_wr_addr, 64'hee00abcd_76543210);
  endtask

  task automatic read_timer_low(input logic [15:0] addr, input logic [1:0] size);
    logic [31:0] rdata;
    logic [31:0] delta;
    int          edges;
    edges = cycle - rel_cycle;
    bus_read(addr, size, rdata);
    check_value("timer_low", rdata, edges);
    if (have_prev_timer) begin
      delta = rdata - prev_timer;
      check_value("timer_low_delta", delta, edges - prev_edges);
    end
    have_prev_timer = 1'b1;
    prev_timer      = rdata;
    prev_edges      = edges;
  endtask

  task automatic run_timer_step(input logic [15:0] addr, input logic [31:0] step,
                                input logic [1:0] size, input int exp_cycles);
    int edges;
    bus_write(addr, step, size, 4'h0);
    edges = 0;
    while (!timer_irq && edges < IRQ_WAIT_LIMIT) begin
      @(negedge clk);
      edges++;
    end
    if (!timer_irq) begin
      errors++;
      $display("timer_irq did not rise within %0d cycles of the step write", IRQ_WAIT_LIMIT);
    end else begin
      check_value("timer_irq_delay", edges, exp_cycles);
    end
  endtask

  task automatic check_signal(input logic [63:0] sel, input logic [63:0] expected);
    case (sel)
      64'd0:   check_value("ext_irq", ext_irq, expected);
      64'd1:   check_value("timer_irq", timer_irq, expected);
      64'd2:   check_value("data_desc_valid", data_desc_valid, expected);
      64'd3:   check_value("interrupt_in_ack", interrupt_in_ack, expected);
      default: begin
        errors++;
        $display("Unknown signal selector %0d in the stimulus file", sel);
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus file
  ////////////////////////////////////////////////////////////

  task automatic load_stimulus();
    int                fd;
    int                rc;
    logic [8*120-1:0]  line;
    logic [63:0]       f_op;
    logic [63:0]       f_addr;
    logic [63:0]       f_data;
    logic [63:0]       f_size;
    logic [63:0]       f_exp;
    n_lines = 0;
    fd = $fopen("tb/io_core_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the stimulus file tb/io_core_stimulus.txt");
    end else begin
      while (!$feof(fd) && n_lines < MAX_LINES) begin
        line = '0;
        rc = $fgets(line, fd);
        // Comment and blank lines do not give five fields
        if (rc != 0 &&
            $sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_data, f_size, f_exp) == 5) begin
          st_op[n_lines]   = f_op;
          st_addr[n_lines] = f_addr;
          st_data[n_lines] = f_data;
          st_size[n_lines] = f_size;
          st_exp[n_lines]  = f_exp;
          n_lines++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_line(input int i);
    logic [31:0] rdata;
    case (st_op[i])
      64'h1: bus_write(st_addr[i], st_data[i], st_size[i], st_exp[i]);
      64'h2: begin
        bus_read(st_addr[i], st_size[i], rdata);
        check_value("dbus_rsp_data", rdata, st_exp[i]);
      end
      64'h3: pulse_tag(st_data[i]);
      64'h4: repeat (st_data[i]) @(negedge clk);
      64'h5: data_desc_ready = st_data[i][0];
      64'h6: send_descriptor(st_addr[i], st_data[i], st_exp[i]);
      64'h7: read_timer_low(st_addr[i], st_size[i]);
      64'h8: check_signal(st_addr[i], st_exp[i]);
      64'h9: run_timer_step(st_addr[i], st_data[i], st_size[i], st_exp[i]);
      default: begin
        errors++;
        $display("Unknown operation %h on stimulus line %0d", st_op[i], i);
      end
    endcase
  endtask

  initial begin : watchdog
    wait (limit_set);
    while (cycle < limit) begin
      @(posedge clk);
    end
    $display("Timeout, the stimulus did not finish within %0d cycles", limit);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Simulation failed");
    $finish;
  end

  initial begin : main
    rst                 = 1'b1;
    dbus_valid          = 1'b0;
    dbus_wr             = 1'b0;
    dbus_addr           = '0;
    dbus_wdata          = 32'd0;
    dbus_size           = 2'd0;
    mem_rd_data         = 32'd0;
    mem_rd_valid        = 1'b0;
    in_desc             = IN_DESC;
    in_desc_valid       = 1'b1;
    data_desc_ready     = 1'b0;
    recv_dram_tag       = 5'd0;
    recv_dram_tag_valid = 1'b0;
    interrupt_in        = 1'b0;
    core_id             = CORE_ID;
    errors              = 0;
    checks              = 0;
    cycle               = 0;
    have_prev_timer     = 1'b0;
    void'($urandom(32'h9a903294));
    load_stimulus();
    // Waits plus a fixed budget per line and for the DRAM address writes, and the reset
    limit = 8 + 20 * (n_lines + 1);
    for (int i = 0; i < n_lines; i++) begin
      if (st_op[i] == 64'h4) begin
        limit += st_data[i];
      end
    end
    limit_set = 1'b1;
    repeat (8) @(negedge clk);
    rst       = 1'b0;
    rel_cycle = cycle;
    for (int i = 0; i < n_lines; i++) begin
      run_line(i);
    end
    dram_addr_writes();
    repeat (2) @(negedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tb/io_core_stimulus.txt
# Columns (hex): op addr data size expected
# op 1 write, 2 read, 3 tag, 4 wait, 5 ready, 6 send, 7 timer read, 8 signal, 9 timer step
1 8000 89abcdef 2 0
1 8004 01234567 2 0
1 8005 5a5a5a5a 0 0
6 8038 00000001 2 01235a6789abcdef
2 8040 0 2 55667788
2 8044 0 2 11223344
1 8039 00000001 0 0
2 8050 0 2 0000000a
5 0 1 0 0
2 804c 0 2 00000101
5 0 0 0 0
2 804c 0 2 00000001
3 0 03 0 0
3 0 00 0 0
3 0 09 0 0
3 0 1f 0 0
4 0 2 0 0
2 8048 0 2 80000208
1 803a 00090000 2 0
2 8048 0 2 80000008
8 0 0 0 0
1 803c 0000005f 2 0
8 0 0 0 1
2 805c 0 2 00005fe0
7 8054 0 2 0
4 0 6 0 0
7 8054 0 2 0
1 803c 0000007f 2 0
9 8014 5 2 6
1 803d 00002000 2 0
8 1 0 0 0
1 803d 00001000 2 0
1 0010 11223344 2 f
1 0011 aaaaaaaa 0 2
1 0012 beefbeef 1 c
2 0010 0 2 beefaa44
1 0020 cafef00d 2 f
2 0020 0 2 cafef00d

// File: all.f
rtl/io_core_pkg.sv
rtl/io_decode.sv
rtl/io_control_regs.sv
rtl/core_timer.sv
rtl/dram_recv_flags.sv
rtl/io_read_mux.sv
rtl/io_core_top.sv
tb/tb_io_core.sv

// File: Bender.yml
package:
  name: io_core

sources:
  - rtl/io_core_pkg.sv
  - rtl/io_decode.sv
  - rtl/io_control_regs.sv
  - rtl/core_timer.sv
  - rtl/dram_recv_flags.sv
  - rtl/io_read_mux.sv
  - rtl/io_core_top.sv
  - target: test
    files:
      - tb/tb_io_core.sv
